//--- logic/rx_buffer_pkg.sv
package rx_buffer_pkg;

  // --------------------------------------------------
  // RAM word and data port
  // --------------------------------------------------

  // Bits per RAM word and per read data port
  localparam int WORD_BITS = 64;

  // Byte lane part of a byte address
  localparam int LANE_BITS = 3;

  // --------------------------------------------------
  // Read word sizes
  // --------------------------------------------------

  localparam int WS_BITS = 3;

  localparam logic [WS_BITS-1:0] WS_8BIT  = 3'd0;
  localparam logic [WS_BITS-1:0] WS_16BIT = 3'd1;
  localparam logic [WS_BITS-1:0] WS_32BIT = 3'd2;
  localparam logic [WS_BITS-1:0] WS_64BIT = 3'd3;

endpackage

//--- logic/rx_ram_if.sv
`timescale 1ns/1ps

interface rx_ram_if #(
  parameter int ADDR_WIDTH = 8
);
  import rx_buffer_pkg::*;

  // Write port, filled from the dispatch FIFO
  logic                  wr_en;
  logic [ADDR_WIDTH-1:0] wr_addr;
  logic [WORD_BITS-1:0]  wr_data;

  // Read port, used by the parser side
  logic [ADDR_WIDTH-1:0] rd_addr;
  logic [WORD_BITS-1:0]  rd_data;

  modport filler (output wr_en, output wr_addr, output wr_data);
  modport reader (output rd_addr, input rd_data);
  modport ram    (input wr_en, input wr_addr, input wr_data, input rd_addr, output rd_data);

endinterface

//--- logic/rx_fill_ctrl.sv
`timescale 1ns/1ps

module rx_fill_ctrl #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                i_clk,
  input  logic                                i_areset,
  input  logic                                i_parser_busy,
  input  logic                                i_dispatch_packet_available,
  input  logic                                i_dispatch_fifo_empty,
  input  logic                                i_dispatch_fifo_rd_valid,
  input  logic [rx_buffer_pkg::WORD_BITS-1:0] i_dispatch_fifo_rd_data,
  input  logic                                i_read_busy,
  output logic                                o_fill_busy,
  output logic                                o_dispatch_fifo_rd_start,
  output logic                                o_dispatch_packet_read,
  rx_ram_if.filler                            ram_wr
);

  localparam logic ST_IDLE = 1'b0;
  localparam logic ST_FILL = 1'b1;

  logic                  state;
  logic [ADDR_WIDTH-1:0] wr_addr_cnt;
  logic                  rd_start_reg;
  logic                  packet_read_reg;
  logic                  fill_start;
  logic                  fill_done;

  // --------------------------------------------------
  // Start and end of a packet fill
  // --------------------------------------------------

  // Only start when both the parser and the read port are quiet
  assign fill_start = (state == ST_IDLE) && !i_read_busy && !i_parser_busy &&
                      i_dispatch_packet_available && !i_dispatch_fifo_empty;

  // FIFO drained, no more words in flight
  assign fill_done = (state == ST_FILL) && !i_dispatch_fifo_rd_valid && i_dispatch_fifo_empty;

  // Raised in the start cycle already, so a read in that cycle loses
  assign o_fill_busy = fill_start || (state == ST_FILL);

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state           <= ST_IDLE;
      wr_addr_cnt     <= '0;
      rd_start_reg    <= 1'b0;
      packet_read_reg <= 1'b0;
    end else begin
      rd_start_reg    <= fill_start;
      packet_read_reg <= fill_done;
      if (fill_start) begin
        state       <= ST_FILL;
        wr_addr_cnt <= '0;
      end else if (fill_done) begin
        state <= ST_IDLE;
      end else if (ram_wr.wr_en) begin
        wr_addr_cnt <= wr_addr_cnt + 1'b1;
      end
    end
  end

  // One RAM word per valid FIFO word
  assign ram_wr.wr_en   = (state == ST_FILL) && i_dispatch_fifo_rd_valid;
  assign ram_wr.wr_addr = wr_addr_cnt;
  assign ram_wr.wr_data = i_dispatch_fifo_rd_data;

  assign o_dispatch_fifo_rd_start = rd_start_reg;
  assign o_dispatch_packet_read   = packet_read_reg;

endmodule

//--- logic/rx_packet_ram.sv
`timescale 1ns/1ps

module rx_packet_ram #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic  i_clk,
  input  logic  i_areset,
  rx_ram_if.ram ram_port
);
  import rx_buffer_pkg::*;

  localparam int DEPTH = 2 ** ADDR_WIDTH;

  logic                  sreset_meta;
  logic                  sreset;
  logic                  wr_en_q;
  logic [ADDR_WIDTH-1:0] wr_addr_q;
  logic [WORD_BITS-1:0]  wr_data_q;
  logic [ADDR_WIDTH-1:0] rd_addr_q;
  logic [WORD_BITS-1:0]  rd_data_q;
  logic [WORD_BITS-1:0]  mem [0:DEPTH-1];

  // Synchronous reset for the block RAM input stage
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      sreset_meta <= 1'b1;
      sreset      <= 1'b1;
    end else begin
      sreset_meta <= 1'b0;
      sreset      <= sreset_meta;
    end
  end

  // --------------------------------------------------
  // Registered inputs
  // --------------------------------------------------

  always_ff @(posedge i_clk) begin
    if (sreset) begin
      wr_en_q   <= 1'b0;
      wr_addr_q <= '0;
      wr_data_q <= '0;
      rd_addr_q <= '0;
    end else begin
      wr_en_q   <= ram_port.wr_en;
      wr_addr_q <= ram_port.wr_addr;
      wr_data_q <= ram_port.wr_data;
      rd_addr_q <= ram_port.rd_addr;
    end
  end

  // Storage with registered read, two edges from rd_addr to rd_data
  always_ff @(posedge i_clk) begin
    if (wr_en_q) begin
      mem[wr_addr_q] <= wr_data_q;
    end
    rd_data_q <= mem[rd_addr_q];
  end

  assign ram_port.rd_data = rd_data_q;

endmodule

//--- logic/rx_access_port.sv
`timescale 1ns/1ps

module rx_access_port #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                           i_clk,
  input  logic                                           i_areset,
  input  logic [ADDR_WIDTH+rx_buffer_pkg::LANE_BITS-1:0] i_access_port_addr,
  input  logic [rx_buffer_pkg::WS_BITS-1:0]              i_access_port_wordsize,
  input  logic                                           i_access_port_rd_en,
  input  logic                                           i_fill_busy,
  output logic                                           o_read_busy,
  output logic                                           o_access_port_wait,
  output logic                                           o_access_port_rd_dv,
  output logic [rx_buffer_pkg::WORD_BITS-1:0]            o_access_port_rd_data,
  rx_ram_if.reader                                       ram_rd
);
  import rx_buffer_pkg::*;

  localparam logic [2:0] ST_IDLE       = 3'd0;
  localparam logic [2:0] ST_SINGLE_DLY = 3'd1;
  localparam logic [2:0] ST_SINGLE     = 3'd2;
  localparam logic [2:0] ST_FIRST_DLY  = 3'd3;
  localparam logic [2:0] ST_FIRST      = 3'd4;
  localparam logic [2:0] ST_SECOND     = 3'd5;

  logic [2:0]             state;
  logic [2:0]             state_next;
  logic                   wait_reg;
  logic                   dv_reg;
  logic [WORD_BITS-1:0]   out_reg;
  logic [LANE_BITS-1:0]   lane_reg;
  logic [WS_BITS-1:0]     ws_reg;
  logic [ADDR_WIDTH-1:0]  word_addr_reg;

  logic [ADDR_WIDTH-1:0]  req_word_addr;
  logic [LANE_BITS-1:0]   req_lane;
  logic [3:0]             req_bytes;
  logic                   accept;
  logic                   straddle;
  logic                   finish;

  logic [3:0]             byte_count;
  logic [3:0]             head_bytes;
  logic [LANE_BITS+2:0]   lane_shift;
  logic [6:0]             drop_shift;
  logic [6:0]             head_shift;
  logic [WORD_BITS-1:0]   single_data;
  logic [WORD_BITS-1:0]   tail_data;
  logic [WORD_BITS-1:0]   head_data;

  function automatic logic [3:0] bytes_of(input logic [WS_BITS-1:0] ws);
    case (ws)
      WS_8BIT:  bytes_of = 4'd1;
      WS_16BIT: bytes_of = 4'd2;
      WS_32BIT: bytes_of = 4'd4;
      default:  bytes_of = 4'd8;
    endcase
  endfunction

  // --------------------------------------------------
  // Request decode
  // --------------------------------------------------

  assign req_word_addr = i_access_port_addr[ADDR_WIDTH+LANE_BITS-1:LANE_BITS];
  assign req_lane      = i_access_port_addr[LANE_BITS-1:0];
  assign req_bytes     = bytes_of(i_access_port_wordsize);

  // Codes above 64 bit are dropped without wait or data
  assign accept = (state == ST_IDLE) && i_access_port_rd_en && !i_fill_busy &&
                  (i_access_port_wordsize <= WS_64BIT);

  // Last byte beyond lane 7 means the next word is needed
  assign straddle = ({1'b0, req_lane} + req_bytes) > 4'd8;

  assign finish = (state == ST_SINGLE) || (state == ST_SECOND);

  always_comb begin
    state_next = state;
    case (state)
      ST_IDLE: begin
        if (accept) begin
          state_next = straddle ? ST_FIRST_DLY : ST_SINGLE_DLY;
        end
      end
      ST_SINGLE_DLY: state_next = ST_SINGLE;
      ST_SINGLE:     state_next = ST_IDLE;
      ST_FIRST_DLY:  state_next = ST_FIRST;
      ST_FIRST:      state_next = ST_SECOND;
      default:       state_next = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state    <= ST_IDLE;
      wait_reg <= 1'b0;
      dv_reg   <= 1'b0;
    end else begin
      state  <= state_next;
      dv_reg <= finish;
      if (accept) begin
        wait_reg <= 1'b1;
      end else if (finish) begin
        wait_reg <= 1'b0;
      end
    end
  end

  // Second word address goes out one cycle after the first
  always_comb begin
    case (state)
      ST_IDLE:      ram_rd.rd_addr = req_word_addr;
      ST_FIRST_DLY: ram_rd.rd_addr = word_addr_reg + 1'b1;
      default:      ram_rd.rd_addr = word_addr_reg;
    endcase
  end

  // --------------------------------------------------
  // Byte lane assembly, lane 0 is the top byte
  // --------------------------------------------------

  assign byte_count = bytes_of(ws_reg);
  assign head_bytes = {1'b0, lane_reg} + byte_count - 4'd8;
  assign lane_shift = {lane_reg, 3'b000};
  assign drop_shift = 7'(WORD_BITS) - {byte_count, 3'b000};
  assign head_shift = 7'(WORD_BITS) - {head_bytes, 3'b000};

  assign single_data = (ram_rd.rd_data << lane_shift) >> drop_shift;

  // Tail of the first word moved up to leave room for the head
  assign tail_data = ((ram_rd.rd_data << lane_shift) >> lane_shift) << {head_bytes[2:0], 3'b000};
  assign head_data = ram_rd.rd_data >> head_shift;

  always_ff @(posedge i_clk) begin
    if (accept) begin
      lane_reg      <= req_lane;
      ws_reg        <= i_access_port_wordsize;
      word_addr_reg <= req_word_addr;
    end
    case (state)
      ST_SINGLE: out_reg <= single_data;
      ST_FIRST:  out_reg <= tail_data;
      ST_SECOND: out_reg <= out_reg | head_data;
      default:   out_reg <= out_reg;
    endcase
  end

  assign o_read_busy           = (state != ST_IDLE);
  assign o_access_port_wait    = wait_reg;
  assign o_access_port_rd_dv   = dv_reg;
  assign o_access_port_rd_data = out_reg;

endmodule

//--- logic/nts_rx_buffer.sv
`timescale 1ns/1ps

module nts_rx_buffer #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                           i_clk,
  input  logic                                           i_areset,
  input  logic                                           i_parser_busy,
  input  logic                                           i_dispatch_packet_available,
  input  logic                                           i_dispatch_fifo_empty,
  input  logic                                           i_dispatch_fifo_rd_valid,
  input  logic [rx_buffer_pkg::WORD_BITS-1:0]            i_dispatch_fifo_rd_data,
  output logic                                           o_dispatch_packet_read,
  output logic                                           o_dispatch_fifo_rd_start,
  input  logic [ADDR_WIDTH+rx_buffer_pkg::LANE_BITS-1:0] i_access_port_addr,
  input  logic [rx_buffer_pkg::WS_BITS-1:0]              i_access_port_wordsize,
  input  logic                                           i_access_port_rd_en,
  output logic                                           o_access_port_wait,
  output logic                                           o_access_port_rd_dv,
  output logic [rx_buffer_pkg::WORD_BITS-1:0]            o_access_port_rd_data
);

  // Fill has priority over parser reads
  logic fill_busy;
  logic read_busy;

  rx_ram_if #(.ADDR_WIDTH(ADDR_WIDTH)) ram_bus ();

  // --------------------------------------------------
  // Producer, buffer and consumer
  // --------------------------------------------------

  rx_fill_ctrl #(.ADDR_WIDTH(ADDR_WIDTH)) fill0 (
    .i_clk                       (i_clk),
    .i_areset                    (i_areset),
    .i_parser_busy               (i_parser_busy),
    .i_dispatch_packet_available (i_dispatch_packet_available),
    .i_dispatch_fifo_empty       (i_dispatch_fifo_empty),
    .i_dispatch_fifo_rd_valid    (i_dispatch_fifo_rd_valid),
    .i_dispatch_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .i_read_busy                 (read_busy),
    .o_fill_busy                 (fill_busy),
    .o_dispatch_fifo_rd_start    (o_dispatch_fifo_rd_start),
    .o_dispatch_packet_read      (o_dispatch_packet_read),
    .ram_wr                      (ram_bus.filler)
  );

  rx_packet_ram #(.ADDR_WIDTH(ADDR_WIDTH)) ram0 (
    .i_clk    (i_clk),
    .i_areset (i_areset),
    .ram_port (ram_bus.ram)
  );

  rx_access_port #(.ADDR_WIDTH(ADDR_WIDTH)) port0 (
    .i_clk                  (i_clk),
    .i_areset               (i_areset),
    .i_access_port_addr     (i_access_port_addr),
    .i_access_port_wordsize (i_access_port_wordsize),
    .i_access_port_rd_en    (i_access_port_rd_en),
    .i_fill_busy            (fill_busy),
    .o_read_busy            (read_busy),
    .o_access_port_wait     (o_access_port_wait),
    .o_access_port_rd_dv    (o_access_port_rd_dv),
    .o_access_port_rd_data  (o_access_port_rd_data),
    .ram_rd                 (ram_bus.reader)
  );

endmodule

//--- dv/rx_buffer_checker.sv
`timescale 1ns/1ps

module rx_buffer_checker (
  input logic i_clk,
  input logic i_areset,
  input logic i_fill_busy,
  input logic i_wait,
  input logic i_rd_dv,
  input logic i_rd_start,
  input logic i_packet_read
);

  // Number of failed assertions
  int fail_count = 0;

  dv_one_cycle: assert property (@(posedge i_clk) disable iff (i_areset)
    i_rd_dv |=> !i_rd_dv)
    else begin
      fail_count++;
      $error("rd_dv high for more than one cycle");
    end

  dv_without_wait: assert property (@(posedge i_clk) disable iff (i_areset)
    i_rd_dv |-> !i_wait)
    else begin
      fail_count++;
      $error("wait still high together with rd_dv");
    end

  strobes_apart: assert property (@(posedge i_clk) disable iff (i_areset)
    !(i_rd_start && i_packet_read))
    else begin
      fail_count++;
      $error("rd_start and packet_read high together");
    end

  // A read can only be accepted while no fill holds the RAM
  no_wait_in_fill: assert property (@(posedge i_clk) disable iff (i_areset)
    $rose(i_wait) |-> !$past(i_fill_busy))
    else begin
      fail_count++;
      $error("wait rose while a fill was in progress");
    end

endmodule

bind nts_rx_buffer rx_buffer_checker chk0 (
  .i_clk         (i_clk),
  .i_areset      (i_areset),
  .i_fill_busy   (fill_busy),
  .i_wait        (o_access_port_wait),
  .i_rd_dv       (o_access_port_rd_dv),
  .i_rd_start    (o_dispatch_fifo_rd_start),
  .i_packet_read (o_dispatch_packet_read)
);

//--- dv/rx_buffer_scoreboard.sv
`timescale 1ns/1ps

module rx_buffer_scoreboard #(
  parameter int ADDR_WIDTH = 8
) (
  input  logic                                           i_clk,
  input  logic                                           i_areset,
  input  logic                                           i_parser_busy,
  input  logic                                           i_packet_available,
  input  logic                                           i_fifo_empty,
  input  logic                                           i_fifo_rd_valid,
  input  logic [rx_buffer_pkg::WORD_BITS-1:0]            i_fifo_rd_data,
  input  logic                                           i_rd_start,
  input  logic                                           i_packet_read,
  input  logic [ADDR_WIDTH+rx_buffer_pkg::LANE_BITS-1:0] i_rd_addr,
  input  logic [rx_buffer_pkg::WS_BITS-1:0]              i_rd_wordsize,
  input  logic                                           i_rd_en,
  input  logic                                           i_wait,
  input  logic                                           i_rd_dv,
  input  logic [rx_buffer_pkg::WORD_BITS-1:0]            i_rd_data,
  output int                                             o_reads,
  output int                                             o_mismatches,
  output int                                             o_errors
);
  import rx_buffer_pkg::*;

  localparam int BYTE_ADDR_BITS = ADDR_WIDTH + LANE_BITS;

  logic [WORD_BITS-1:0]      mirror [0:2**ADDR_WIDTH-1];
  logic [ADDR_WIDTH-1:0]     fill_addr;
  logic [BYTE_ADDR_BITS-1:0] exp_addr;
  logic [WS_BITS-1:0]        exp_ws;
  logic [WORD_BITS-1:0]      exp_data;
  logic                      filling;
  logic                      exp_rd_start;
  logic                      exp_packet_read;
  logic                      start;
  logic                      read_busy;
  int                        busy_left;
  int                        dv_due;
  int                        nbytes;
  int                        cycle = 0;
  int                        read_count = 0;
  int                        mismatch_count = 0;
  int                        error_count = 0;

  assign o_reads      = read_count;
  assign o_mismatches = mismatch_count;
  assign o_errors     = error_count;

  task automatic flag_error(input string msg);
    error_count++;
    $display("ERROR at %0t ns: %s", $time, msg);
  endtask

  // Bytes in address order with lane 0 as the top byte of a word
  function automatic logic [WORD_BITS-1:0] read_bytes(input logic [BYTE_ADDR_BITS-1:0] addr,
                                                      input int count);
    logic [WORD_BITS-1:0]      result;
    logic [WORD_BITS-1:0]      word;
    logic [BYTE_ADDR_BITS-1:0] byte_addr;
    int                        shift;
    result = '0;
    for (int i = 0; i < count; i++) begin
      byte_addr = addr + BYTE_ADDR_BITS'(i);
      word      = mirror[byte_addr[BYTE_ADDR_BITS-1:LANE_BITS]];
      shift     = 8 * (7 - int'(byte_addr[LANE_BITS-1:0]));
      result    = (result << 8) | ((word >> shift) & 64'hff);
    end
    return result;
  endfunction

  // --------------------------------------------------
  // Output checks before the model steps one edge
  // --------------------------------------------------

  always @(posedge i_clk) begin
    cycle = cycle + 1;
    if (i_areset) begin
      filling         = 1'b0;
      fill_addr       = '0;
      exp_rd_start    = 1'b0;
      exp_packet_read = 1'b0;
      busy_left       = 0;
      dv_due          = -1;
      if (i_wait || i_rd_dv || i_rd_start || i_packet_read) begin
        flag_error("outputs not low during reset");
      end
    end else begin
      if (i_rd_start !== exp_rd_start) begin
        flag_error("rd_start strobe does not follow the fill start");
      end
      if (i_packet_read !== exp_packet_read) begin
        flag_error("packet_read strobe does not follow the FIFO running empty");
      end
      if (i_wait !== (busy_left > 0)) begin
        flag_error("wait level does not match the read in progress");
      end
      if (i_rd_dv !== (cycle == dv_due)) begin
        if (cycle == dv_due) begin
          flag_error("read accepted but no data valid");
        end else begin
          flag_error("data valid without an accepted read");
        end
      end else if (i_rd_dv && (i_rd_data !== exp_data)) begin
        mismatch_count++;
        $display("MISMATCH at %0t ns: addr 0x%0h size %0d expected 0x%016h actual 0x%016h",
                 $time, exp_addr, exp_ws, exp_data, i_rd_data);
      end

      read_busy = (busy_left > 0);
      if (busy_left > 0) begin
        busy_left--;
      end
      start = !filling && !read_busy && !i_parser_busy && i_packet_available && !i_fifo_empty;
      exp_rd_start    = start;
      exp_packet_read = filling && !i_fifo_rd_valid && i_fifo_empty;
      if (filling && i_fifo_rd_valid) begin
        mirror[fill_addr] = i_fifo_rd_data;
        fill_addr         = fill_addr + 1'b1;
      end

      // Fill wins over a read in the same cycle
      if (!read_busy && i_rd_en && (i_rd_wordsize <= WS_64BIT) && !start && !filling) begin
        nbytes     = 1 << i_rd_wordsize;
        exp_addr   = i_rd_addr;
        exp_ws     = i_rd_wordsize;
        exp_data   = read_bytes(i_rd_addr, nbytes);
        busy_left  = (int'(i_rd_addr[LANE_BITS-1:0]) + nbytes > 8) ? 3 : 2;
        dv_due     = cycle + busy_left + 1;
        read_count++;
      end

      if (start) begin
        filling   = 1'b1;
        fill_addr = '0;
      end else if (exp_packet_read) begin
        filling = 1'b0;
      end
    end
  end

endmodule

//--- dv/tb_rx_buffer.sv
`timescale 1ns/1ps

module tb_rx_buffer;
  import rx_buffer_pkg::*;

  localparam int ADDR_WIDTH       = 6;
  localparam int BYTE_ADDR_BITS   = ADDR_WIDTH + LANE_BITS;
  localparam int NUM_PACKETS      = 8;
  localparam int READS_PER_PACKET = 40;
  localparam int TIMEOUT_CYCLES   = NUM_PACKETS * (16 + 8 + READS_PER_PACKET * 8) + 200;

  logic                      i_clk = 1'b0;
  logic                      i_areset;
  logic                      i_parser_busy;
  logic                      i_dispatch_packet_available;
  logic                      i_dispatch_fifo_empty;
  logic                      i_dispatch_fifo_rd_valid;
  logic [WORD_BITS-1:0]      i_dispatch_fifo_rd_data;
  logic                      o_dispatch_packet_read;
  logic                      o_dispatch_fifo_rd_start;
  logic [BYTE_ADDR_BITS-1:0] i_access_port_addr;
  logic [WS_BITS-1:0]        i_access_port_wordsize;
  logic                      i_access_port_rd_en;
  logic                      o_access_port_wait;
  logic                      o_access_port_rd_dv;
  logic [WORD_BITS-1:0]      o_access_port_rd_data;

  integer seed = 85140;
  int     cycle_count = 0;
  int     reads_checked;
  int     mismatches;
  int     errors;
  int     assert_fails;

  always #2 i_clk = ~i_clk;

  always @(posedge i_clk) begin
    cycle_count <= cycle_count + 1;
  end

  nts_rx_buffer #(.ADDR_WIDTH(ADDR_WIDTH)) dut0 (.*);

  rx_buffer_scoreboard #(.ADDR_WIDTH(ADDR_WIDTH)) sb0 (
    .i_clk              (i_clk),
    .i_areset           (i_areset),
    .i_parser_busy      (i_parser_busy),
    .i_packet_available (i_dispatch_packet_available),
    .i_fifo_empty       (i_dispatch_fifo_empty),
    .i_fifo_rd_valid    (i_dispatch_fifo_rd_valid),
    .i_fifo_rd_data     (i_dispatch_fifo_rd_data),
    .i_rd_start         (o_dispatch_fifo_rd_start),
    .i_packet_read      (o_dispatch_packet_read),
    .i_rd_addr          (i_access_port_addr),
    .i_rd_wordsize      (i_access_port_wordsize),
    .i_rd_en            (i_access_port_rd_en),
    .i_wait             (o_access_port_wait),
    .i_rd_dv            (o_access_port_rd_dv),
    .i_rd_data          (o_access_port_rd_data),
    .o_reads            (reads_checked),
    .o_mismatches       (mismatches),
    .o_errors           (errors)
  );

  // Pulse rd_en for one cycle and wait until wait falls
  task automatic issue_read(input logic [BYTE_ADDR_BITS-1:0] addr, input logic [WS_BITS-1:0] ws);
    i_access_port_rd_en    <= 1'b1;
    i_access_port_addr     <= addr;
    i_access_port_wordsize <= ws;
    @(posedge i_clk);
    i_access_port_rd_en <= 1'b0;
    if (ws <= WS_64BIT) begin
      @(posedge i_clk);
      while (o_access_port_wait) @(posedge i_clk);
    end else begin
      repeat (3) @(posedge i_clk);
    end
  endtask

  // Legal sizes inside the packet with an occasional code 4 to 7
  task automatic random_read(input int len);
    logic [WS_BITS-1:0] ws;
    int                 span;
    if ($unsigned($random(seed)) % 8 == 0) begin
      ws   = WS_BITS'(4 + $unsigned($random(seed)) % 4);
      span = len * 8;
    end else begin
      ws   = WS_BITS'($unsigned($random(seed)) % 4);
      span = len * 8 - (1 << ws) + 1;
    end
    issue_read(BYTE_ADDR_BITS'($unsigned($random(seed)) % span), ws);
  endtask

  // --------------------------------------------------
  // Dispatch FIFO model
  // --------------------------------------------------

  task automatic fill_packet(input int pkt_index, output int len);
    logic [WORD_BITS-1:0] words [0:15];
    int                   gap;
    int                   hold;
    len = 2 + $unsigned($random(seed)) % 15;
    for (int i = 0; i < len; i++) begin
      words[i] = {$random(seed), $random(seed)};
    end
    i_dispatch_packet_available <= 1'b1;
    i_dispatch_fifo_empty       <= 1'b0;
    // Odd packets put a read on the fill start edge
    if (pkt_index % 2 == 1) begin
      i_access_port_rd_en    <= 1'b1;
      i_access_port_addr     <= BYTE_ADDR_BITS'($unsigned($random(seed)) % (len * 8 - 7));
      i_access_port_wordsize <= WS_BITS'($unsigned($random(seed)) % 4);
    end else begin
      // Even packets keep the parser busy for a few cycles first
      hold = 1 + $unsigned($random(seed)) % 3;
      i_parser_busy <= 1'b1;
      repeat (hold) @(posedge i_clk);
      i_parser_busy <= 1'b0;
    end
    @(posedge i_clk);
    i_access_port_rd_en <= 1'b0;
    while (!o_dispatch_fifo_rd_start) @(posedge i_clk);
    i_dispatch_packet_available <= 1'b0;
    for (int i = 0; i < len; i++) begin
      gap = $unsigned($random(seed)) % 3;
      repeat (gap) begin
        i_dispatch_fifo_rd_valid <= 1'b0;
        @(posedge i_clk);
      end
      i_dispatch_fifo_rd_valid <= 1'b1;
      i_dispatch_fifo_rd_data  <= words[i];
      @(posedge i_clk);
    end
    i_dispatch_fifo_rd_valid <= 1'b0;
    i_dispatch_fifo_empty    <= 1'b1;
    @(posedge i_clk);
    while (!o_dispatch_packet_read) @(posedge i_clk);
  endtask

  initial begin
    int len;
    i_areset                    <= 1'b1;
    i_parser_busy               <= 1'b0;
    i_dispatch_packet_available <= 1'b0;
    i_dispatch_fifo_empty       <= 1'b1;
    i_dispatch_fifo_rd_valid    <= 1'b0;
    i_dispatch_fifo_rd_data     <= '0;
    i_access_port_addr          <= '0;
    i_access_port_wordsize      <= '0;
    i_access_port_rd_en         <= 1'b0;
    repeat (2) @(posedge i_clk);
    i_areset <= 1'b0;
    repeat (3) @(posedge i_clk);
    for (int p = 0; p < NUM_PACKETS; p++) begin
      fill_packet(p, len);
      // Aligned 64-bit reads first show where every word landed
      for (int r = 0; r < READS_PER_PACKET; r++) begin
        if (r < len) begin
          issue_read(BYTE_ADDR_BITS'(r * 8), WS_64BIT);
        end else begin
          random_read(len);
        end
      end
    end
    repeat (4) @(posedge i_clk);
    assert_fails = dut0.chk0.fail_count;
    $display("Summary: %0d reads checked, %0d mismatches, %0d other errors, %0d assertion failures",
             reads_checked, mismatches, errors, assert_fails);
    if (mismatches == 0 && errors == 0 && assert_fails == 0 && reads_checked > 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

  initial begin
    wait (cycle_count >= TIMEOUT_CYCLES);
    $display("Timeout after %0d cycles, the test did not finish", cycle_count);
    $display(">>> FAIL");
    $finish;
  end

endmodule

//--- sources.f
logic/rx_buffer_pkg.sv
logic/rx_ram_if.sv
logic/rx_fill_ctrl.sv
logic/rx_packet_ram.sv
logic/rx_access_port.sv
logic/nts_rx_buffer.sv
dv/rx_buffer_checker.sv
dv/rx_buffer_scoreboard.sv
dv/tb_rx_buffer.sv

//--- Makefile
OBJ_DIR := obj_dir

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_rx_buffer \
	  -f sources.f --Mdir $(OBJ_DIR) -o sim_rx_buffer

run: compile
	./$(OBJ_DIR)/sim_rx_buffer +verilator+error+limit+1000 | tee sim.log
	@if grep -q '>>> FAIL' sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q '>>> PASS' sim.log || (echo "Simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJ_DIR) sim.log
